// ==== sim.f ====
source/merge_pkg.sv
source/run_fifo.sv
source/merge_control.sv
source/merge_datapath.sv
source/wb_merge_port.sv
source/merge_top.sv
verification/tb_clock_gen.sv
verification/merge_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the merge stage testbench with Verilator and runs it once.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module merge_top_tb -f sim.f -o merge_sim
./obj_dir/merge_sim > sim.log 2>&1
cat sim.log

# The log decides the result, since the simulator exits cleanly either way.
if grep -q "Regression passed" sim.log; then
   echo "simulation passed"
   exit 0
fi
echo "simulation failed"
exit 1

// ==== verification/merge_top_tb.sv ====
`timescale 1ns/1ps

module merge_top_tb;
   import merge_pkg::*;

   localparam int ACK_LIMIT  = 40;    // cycles a read may wait for its ack.
   localparam int WR_LIMIT   = 20;    // cycles before a held-off write is dropped and retried.
   localparam int POLL_LIMIT = 200;   // idle polls allowed while waiting on the merge.

   logic        clk;
   logic        rst_n, wb_cyc, wb_stb, wb_we, wb_ack;
   logic [1:0]  wb_adr;
   logic [31:0] wb_dat_w, wb_dat_r;

   word_t      run_a[$], run_b[$];         // one run of each stream, without its terminator.
   word_t      stream_a[$], stream_b[$];   // whole streams with terminators.
   word_t      sched_word[$];              // host write order.
   bit         sched_from_a[$];
   merge_out_t expected[$], received[$];
   int         pair_count, put_a, put_b, ends_a, ends_b, stall_count;
   int         tests, checks, errors;

   tb_clock_gen u_clk (.o_clk(clk));

   merge_top UUT (
      .i_clk(clk), .i_rst_n(rst_n), .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we),
      .i_wb_adr(wb_adr), .i_wb_dat(wb_dat_w), .o_wb_dat(wb_dat_r), .o_wb_ack(wb_ack));

   task automatic abort_on_timeout(input string what);
      $display("Timeout at %0t ns: %s.", $time, what);
      $display("Regression failed");
      $finish;
   endtask

   task automatic compare_out(input merge_out_t got, input merge_out_t exp, input int idx);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t ns: record %0d is lane %0b word %0d, expected lane %0b word %0d.",
                  $time, idx, got.lane, got.word, exp.lane, exp.word);
      end
   endtask

   task automatic compare_status(input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t ns: finished bit is %0b, expected %0b.", $time, got, exp);
      end
   endtask

   task automatic compare_valid(input logic got, input logic exp, input string where);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t ns: valid bit is %0b %s, expected %0b.", $time, got, where, exp);
      end
   endtask

   task automatic bus_idle();
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = 2'd0;
      wb_dat_w = 32'd0;
   endtask

   // a write the port holds off past WR_LIMIT is dropped, so the caller can read and retry.
   task automatic wb_write(input logic [1:0] adr, input word_t w, output bit acked);
      int n;
      n = 0;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_adr   = adr;
      wb_dat_w = {16'd0, w};
      @(negedge clk);
      while (!wb_ack && n < WR_LIMIT) begin
         @(negedge clk);
         n++;
      end
      acked = wb_ack;
      bus_idle();
   endtask

   task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
      int n;
      n = 0;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = 1'b0;
      wb_adr = adr;
      @(negedge clk);
      while (!wb_ack) begin
         n++;
         if (n > ACK_LIMIT) abort_on_timeout("a read got no ack");
         @(negedge clk);
      end
      data = wb_dat_r;   // ack and data come from the same register edge.
      bus_idle();
   endtask

   // puts the DUT into reset and clears the model for a new test.
   task automatic start_test();
      @(negedge clk);
      rst_n = 1'b0;
      bus_idle();
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      stream_a.delete();
      stream_b.delete();
      expected.delete();
      received.delete();
      pair_count  = 0;
      stall_count = 0;
   endtask

   // reference merge of run_a and run_b. Ties take A first, one zero ends the run.
   task automatic add_pair();
      merge_out_t rec;
      int         ia, ib;
      ia = 0;
      ib = 0;
      rec.lane = pair_count[0];   // lanes go 0, 1, 0 over the runs.
      while (ia < run_a.size() || ib < run_b.size()) begin
         if (ib >= run_b.size() || (ia < run_a.size() && run_a[ia] <= run_b[ib])) begin
            rec.word = run_a[ia];
            ia++;
         end else begin
            rec.word = run_b[ib];
            ib++;
         end
         expected.push_back(rec);
      end
      rec.word = '0;
      expected.push_back(rec);
      foreach (run_a[i]) stream_a.push_back(run_a[i]);
      stream_a.push_back('0);
      foreach (run_b[i]) stream_b.push_back(run_b[i]);
      stream_b.push_back('0);
      pair_count++;
   endtask

   task automatic queue_word(input bit from_a);
      word_t w;
      if (from_a) begin
         w = stream_a[put_a];
         put_a++;
         if (w == '0) ends_a++;
      end else begin
         w = stream_b[put_b];
         put_b++;
         if (w == '0) ends_b++;
      end
      sched_from_a.push_back(from_a);
      sched_word.push_back(w);
   endtask

   // the other stream's next word goes in before a pair closes, so the stage does not
   // see both queues drained after a terminator pair and stop early.
   task automatic schedule_word(input bit from_a);
      if (from_a && stream_a[put_a] == '0 && ends_b > ends_a && put_b < stream_b.size())
         queue_word(1'b0);
      if (!from_a && stream_b[put_b] == '0 && ends_a > ends_b && put_a < stream_a.size())
         queue_word(1'b1);
      queue_word(from_a);
   endtask

   // orders the host writes so each head the merge needs is written first.
   task automatic build_schedule();
      int    ca, cb;
      word_t ha, hb;
      ca = 0;
      cb = 0;
      put_a  = 0;
      put_b  = 0;
      ends_a = 0;
      ends_b = 0;
      sched_word.delete();
      sched_from_a.delete();
      while (ca < stream_a.size()) begin
         if (put_a == ca) schedule_word(1'b1);
         if (put_b == cb) schedule_word(1'b0);
         ha = stream_a[ca];
         hb = stream_b[cb];
         if (ha == '0 && hb == '0) begin
            ca++;
            cb++;
         end else if (ha == '0 || (hb != '0 && hb < ha)) begin
            cb++;
         end else begin
            ca++;
         end
      end
   endtask

   task automatic drain_output();
      logic [31:0] data;
      int          n;
      n = 0;
      wb_read(ADDR_OUT, data);
      while (data[17] && n < 4 * OUT_DEPTH) begin
         received.push_back(merge_out_t'(data[16:0]));
         wb_read(ADDR_OUT, data);
         n++;
      end
   endtask

   task automatic run_streams();
      bit          acked;
      int          tries, idle;
      logic [31:0] data;
      build_schedule();
      foreach (sched_word[i]) begin
         tries = 0;
         wb_write(sched_from_a[i] ? ADDR_A : ADDR_B, sched_word[i], acked);
         while (!acked) begin
            stall_count++;
            drain_output();   // reading frees the output queue so the merge moves again.
            tries++;
            if (tries > POLL_LIMIT) abort_on_timeout("an input queue never took a word");
            wb_write(sched_from_a[i] ? ADDR_A : ADDR_B, sched_word[i], acked);
         end
      end
      idle = 0;
      while (received.size() < expected.size()) begin
         wb_read(ADDR_OUT, data);
         if (data[17]) begin
            received.push_back(merge_out_t'(data[16:0]));
         end else begin
            idle++;
            if (idle > POLL_LIMIT) abort_on_timeout("merged records stopped arriving");
         end
      end
   endtask

   task automatic check_results();
      logic [31:0] data;
      int          polls;
      checks++;
      if (received.size() != expected.size()) begin
         errors++;
         $display("Error at %0t ns: read %0d records, expected %0d.",
                  $time, received.size(), expected.size());
      end
      foreach (expected[i]) compare_out(received[i], expected[i], i);
      wb_read(ADDR_OUT, data);
      compare_valid(data[17], 1'b0, "after the last record");
      polls = 0;
      wb_read(ADDR_STAT, data);
      while (!data[0] && polls < POLL_LIMIT) begin
         wb_read(ADDR_STAT, data);
         polls++;
      end
      compare_status(data[0], 1'b1);
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests++;
      $display("%s: %0d records, %s", name, expected.size(),
               (errors == errs_before) ? "ok" : "mismatch");
   endtask

   task automatic fill_random(input bit to_a);
      word_t tmp[$];
      int    len;
      len = $urandom_range(10, 0);
      repeat (len) tmp.push_back(word_t'($urandom_range(65535, 1)));
      tmp.sort();   // runs must ascend.
      if (to_a) run_a = tmp;
      else run_b = tmp;
   endtask

   task automatic test_single_pair();
      int errs;
      errs = errors;
      start_test();
      run_a = '{5, 9, 14};
      run_b = '{2, 9, 30};
      add_pair();
      run_streams();
      check_results();
      report_test("single pair", errs);
   endtask

   task automatic test_uneven_runs();
      int errs;
      errs = errors;
      start_test();
      run_a = '{4, 4, 8};
      run_b = '{4, 6, 6, 40, 41};   // three equal fours across both streams.
      add_pair();
      run_a.delete();               // a lone zero on A.
      run_b = '{10, 11};
      add_pair();
      run_a = '{7};
      run_b.delete();
      add_pair();
      run_streams();
      check_results();
      report_test("uneven and empty runs", errs);
   endtask

   task automatic test_lane_toggle();
      int errs;
      errs = errors;
      start_test();
      run_a = '{1, 5};
      run_b = '{3};
      add_pair();
      run_a = '{2};
      run_b = '{2, 8};
      add_pair();
      run_a = '{9, 10, 11};
      run_b = '{4};
      add_pair();
      run_streams();
      check_results();
      report_test("lane toggle", errs);
   endtask

   task automatic test_back_pressure();
      int errs, p, i;
      errs = errors;
      start_test();
      for (p = 0; p < 2; p++) begin
         run_a.delete();
         run_b.delete();
         for (i = 1; i <= 12; i++) begin
            run_a.push_back(word_t'(i * 10));
            run_b.push_back(word_t'(i * 10 + 5));
         end
         add_pair();
      end
      run_streams();   // nothing is read until the first write is held off.
      checks++;
      if (stall_count == 0) begin
         errors++;
         $display("The port never held off a write while the queues were full.");
      end
      check_results();
      report_test("back-pressure", errs);
   endtask

   task automatic test_random_runs();
      int errs;
      errs = errors;
      start_test();
      repeat (5) begin
         fill_random(1'b1);
         fill_random(1'b0);
         add_pair();
      end
      run_streams();
      check_results();
      report_test("random runs", errs);
   endtask

   task automatic test_finished_state();
      int          errs;
      bit          acked;
      logic [31:0] data;
      errs = errors;
      start_test();
      wb_read(ADDR_STAT, data);
      compare_status(data[0], 1'b0);   // no stream has ended since reset.
      run_a = '{20, 30};
      run_b = '{25};
      add_pair();
      run_streams();
      check_results();
      // the stage stays finished, so late words are queued but never merged.
      wb_write(ADDR_A, 16'd40, acked);
      if (acked) wb_write(ADDR_B, 16'd35, acked);
      if (acked) wb_write(ADDR_A, 16'd0, acked);
      if (acked) wb_write(ADDR_B, 16'd0, acked);
      checks++;
      if (!acked) begin
         errors++;
         $display("A write after the finished state was never acked.");
      end
      repeat (4) begin
         wb_read(ADDR_OUT, data);
         compare_valid(data[17], 1'b0, "after finished");
      end
      wb_read(ADDR_STAT, data);
      compare_status(data[0], 1'b1);
      report_test("finished state", errs);
   endtask

   initial begin
      rst_n  = 1'b0;
      tests  = 0;
      checks = 0;
      errors = 0;
      bus_idle();
      void'($urandom(32'hd07d_3722));
      test_single_pair();
      test_uneven_runs();
      test_lane_toggle();
      test_back_pressure();
      test_random_runs();
      test_finished_state();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
   output logic o_clk
);

   initial o_clk = 1'b0;
   always #5 o_clk = ~o_clk;   // 10 ns period.

endmodule

// ==== source/merge_top.sv ====
`timescale 1ns/1ps

module merge_top (
   input  logic        i_clk,
   input  logic        i_rst_n,
   input  logic        i_wb_cyc,
   input  logic        i_wb_stb,
   input  logic        i_wb_we,
   input  logic [1:0]  i_wb_adr,
   input  logic [31:0] i_wb_dat,
   output logic [31:0] o_wb_dat,
   output logic        o_wb_ack
);
   import merge_pkg::*;

   logic        push_a, push_b, pop_a, pop_b;
   logic        a_full, b_full, a_empty, b_empty;
   word_t       push_word, head_a, head_b;
   logic        out_push, out_pop, out_full, out_empty;
   merge_out_t  out_rec, out_head;
   head_flags_t flags;
   merge_cmd_t  cmd;
   logic        lane, finished;

   wb_merge_port u_port (
      .i_clk, .i_rst_n, .i_wb_cyc, .i_wb_stb, .i_wb_we, .i_wb_adr, .i_wb_dat,
      .o_wb_dat, .o_wb_ack, .i_a_full(a_full), .i_b_full(b_full),
      .o_push_a(push_a), .o_push_b(push_b), .o_push_word(push_word),
      .i_out_head(out_head), .i_out_empty(out_empty), .o_pop_out(out_pop),
      .i_finished(finished));

   // input queues for stream A and stream B.
   run_fifo #(.payload_t(word_t), .DEPTH(IN_DEPTH)) u_fifo_a (
      .i_clk, .i_rst_n, .i_push(push_a), .i_data(push_word), .i_pop(pop_a),
      .o_head(head_a), .o_full(a_full), .o_empty(a_empty));

   run_fifo #(.payload_t(word_t), .DEPTH(IN_DEPTH)) u_fifo_b (
      .i_clk, .i_rst_n, .i_push(push_b), .i_data(push_word), .i_pop(pop_b),
      .o_head(head_b), .o_full(b_full), .o_empty(b_empty));

   // merged records wait here until the host reads them.
   run_fifo #(.payload_t(merge_out_t), .DEPTH(OUT_DEPTH)) u_fifo_out (
      .i_clk, .i_rst_n, .i_push(out_push), .i_data(out_rec), .i_pop(out_pop),
      .o_head(out_head), .o_full(out_full), .o_empty(out_empty));

   merge_datapath u_datapath (
      .i_clk, .i_rst_n, .i_head_a(head_a), .i_head_b(head_b),
      .i_a_empty(a_empty), .i_b_empty(b_empty), .i_cmd(cmd), .i_lane(lane),
      .o_flags(flags), .o_pop_a(pop_a), .o_pop_b(pop_b), .o_push(out_push),
      .o_out(out_rec));

   merge_control u_control (
      .i_clk, .i_rst_n, .i_flags(flags), .i_head_a(head_a), .i_head_b(head_b),
      .i_out_full(out_full), .o_cmd(cmd), .o_lane(lane), .o_finished(finished));

endmodule

// ==== source/wb_merge_port.sv ====
`timescale 1ns/1ps

module wb_merge_port (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_wb_cyc,
   input  logic                  i_wb_stb,
   input  logic                  i_wb_we,
   input  logic [1:0]            i_wb_adr,
   input  logic [31:0]           i_wb_dat,
   output logic [31:0]           o_wb_dat,
   output logic                  o_wb_ack,
   input  logic                  i_a_full,
   input  logic                  i_b_full,
   output logic                  o_push_a,
   output logic                  o_push_b,
   output merge_pkg::word_t      o_push_word,
   input  merge_pkg::merge_out_t i_out_head,
   input  logic                  i_out_empty,
   output logic                  o_pop_out,
   input  logic                  i_finished
);
   import merge_pkg::*;

   logic        req;          // a new request not yet answered.
   logic        wr_a;
   logic        wr_b;
   logic        blocked;      // the target input queue has no room.
   logic        accept;
   logic [31:0] rd_data;

   // the ack of the previous cycle masks the request the master still holds.
   assign req     = i_wb_cyc & i_wb_stb & ~o_wb_ack;
   assign wr_a    = req & i_wb_we & (i_wb_adr == ADDR_A);
   assign wr_b    = req & i_wb_we & (i_wb_adr == ADDR_B);
   assign blocked = (wr_a & i_a_full) | (wr_b & i_b_full);
   assign accept  = req & ~blocked;   // back-pressure just delays the ack.

   // pop at the same edge that captures the head so the two stay paired.
   assign o_pop_out = accept & ~i_wb_we & (i_wb_adr == ADDR_OUT) & ~i_out_empty;

   always_comb begin
      case (i_wb_adr)
         // bit 17 is valid, then lane and word.
         ADDR_OUT:  rd_data = i_out_empty ? 32'd0 : {14'd0, 1'b1, i_out_head};
         ADDR_STAT: rd_data = {31'd0, i_finished};
         default:   rd_data = 32'd0;   // the stream registers are write only.
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_wb_ack <= 1'b0;
         o_push_a <= 1'b0;
         o_push_b <= 1'b0;
      end else begin
         o_wb_ack <= accept;                 // one cycle pulse per accepted request.
         o_push_a <= wr_a & ~i_a_full;
         o_push_b <= wr_b & ~i_b_full;
      end
   end

   always_ff @(posedge i_clk) begin
      if (accept & i_wb_we) begin
         o_push_word <= i_wb_dat[WORD_W-1:0];   // upper bus bits are ignored.
      end
      if (accept & ~i_wb_we) begin
         o_wb_dat <= rd_data;
      end
   end

endmodule

// ==== source/merge_datapath.sv ====
`timescale 1ns/1ps

module merge_datapath (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  merge_pkg::word_t       i_head_a,
   input  merge_pkg::word_t       i_head_b,
   input  logic                   i_a_empty,
   input  logic                   i_b_empty,
   input  merge_pkg::merge_cmd_t  i_cmd,
   input  logic                   i_lane,
   output merge_pkg::head_flags_t o_flags,
   output logic                   o_pop_a,
   output logic                   o_pop_b,
   output logic                   o_push,
   output merge_pkg::merge_out_t  o_out
);
   import merge_pkg::*;

   logic  a_last_zero;   // set when the word just taken from A was a terminator.
   logic  b_last_zero;
   logic  terminator;    // this cycle closes a merged run.
   word_t sel_word;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         a_last_zero <= 1'b0;
         b_last_zero <= 1'b0;
      end else begin
         if (i_cmd.pop_a) begin
            a_last_zero <= (i_head_a == '0);
         end
         if (i_cmd.pop_b) begin
            b_last_zero <= (i_head_b == '0);
         end
      end
   end

   // flags for the control. The zero tests mean nothing while the queue is empty.
   assign o_flags.a_zero      = (i_head_a == '0);
   assign o_flags.b_zero      = (i_head_b == '0);
   assign o_flags.a_empty     = i_a_empty;
   assign o_flags.b_empty     = i_b_empty;
   assign o_flags.a_last_zero = a_last_zero;
   assign o_flags.b_last_zero = b_last_zero;

   // only a terminator pair pops both queues at once.
   assign terminator = i_cmd.pop_a & i_cmd.pop_b;
   assign sel_word   = i_cmd.select_a ? i_head_a : i_head_b;

   assign o_out.lane = i_lane;                        // record carries the current lane.
   assign o_out.word = terminator ? '0 : sel_word;    // one zero closes the run.

   // the command is already checked by the control and drives the queues as is.
   assign o_pop_a = i_cmd.pop_a;
   assign o_pop_b = i_cmd.pop_b;
   assign o_push  = i_cmd.push;

endmodule

// ==== source/merge_control.sv ====
`timescale 1ns/1ps

module merge_control (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  merge_pkg::head_flags_t i_flags,
   input  merge_pkg::word_t       i_head_a,
   input  merge_pkg::word_t       i_head_b,
   input  logic                   i_out_full,
   output merge_pkg::merge_cmd_t  o_cmd,
   output logic                   o_lane,
   output logic                   o_finished
);
   import merge_pkg::*;

   merge_state_t state;
   merge_state_t next_state;
   logic         a_lte_b;      // A wins ties so equal values keep stream order.
   logic         a_ready;
   logic         b_ready;
   logic         both_term;    // both heads are run terminators.
   logic         all_done;     // both streams ended on a terminator and are drained.

   assign a_lte_b   = (i_head_a <= i_head_b);
   assign a_ready   = ~i_flags.a_empty;
   assign b_ready   = ~i_flags.b_empty;
   assign both_term = a_ready & b_ready & i_flags.a_zero & i_flags.b_zero;
   assign all_done  = i_flags.a_empty & i_flags.b_empty &
                      i_flags.a_last_zero & i_flags.b_last_zero;

   always_comb begin
      next_state = state;
      o_cmd      = '0;   // a stall is the all-zero command.
      case (state)
         NOMINAL: begin
            // both heads are needed before anything can be compared.
            if (a_ready & b_ready) begin
               if (i_flags.a_zero) begin
                  next_state = DONE_A;   // run of A is over, B keeps going.
               end else if (i_flags.b_zero) begin
                  next_state = DONE_B;
               end else if (~i_out_full) begin
                  o_cmd.push     = 1'b1;
                  o_cmd.select_a = a_lte_b;
                  o_cmd.pop_a    = a_lte_b;
                  o_cmd.pop_b    = ~a_lte_b;
               end
            end
         end
         DONE_A: begin
            // drain what is left of the B run.
            if (b_ready) begin
               if (i_flags.b_zero) begin
                  next_state = TOGGLE;
               end else if (~i_out_full) begin
                  o_cmd.push  = 1'b1;   // select_a stays low so the B head goes out.
                  o_cmd.pop_b = 1'b1;
               end
            end
         end
         DONE_B: begin
            if (a_ready) begin
               if (i_flags.a_zero) begin
                  next_state = TOGGLE;
               end else if (~i_out_full) begin
                  o_cmd.push     = 1'b1;
                  o_cmd.select_a = 1'b1;
                  o_cmd.pop_a    = 1'b1;
               end
            end
         end
         TOGGLE: begin
            if (both_term) begin
               // consume both terminators and emit a single zero for the merged run.
               if (~i_out_full) begin
                  o_cmd.push     = 1'b1;
                  o_cmd.select_a = 1'b1;
                  o_cmd.pop_a    = 1'b1;
                  o_cmd.pop_b    = 1'b1;
               end
            end else if (all_done) begin
               next_state = FINISHED;
            end else if (a_ready & b_ready) begin
               next_state = NOMINAL;   // a new pair of runs has started.
            end
         end
         FINISHED: next_state = FINISHED;   // held until reset.
         default:  next_state = NOMINAL;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state  <= NOMINAL;
         o_lane <= 1'b0;
      end else begin
         state <= next_state;
         if (o_cmd.pop_a & o_cmd.pop_b) begin
            o_lane <= ~o_lane;   // the next merged run goes to the other lane.
         end
      end
   end

   assign o_finished = (state == FINISHED);

endmodule

// ==== source/run_fifo.sv ====
`timescale 1ns/1ps

module run_fifo #(
   parameter type payload_t = merge_pkg::word_t,
   parameter int  DEPTH     = merge_pkg::IN_DEPTH
) (
   input  logic     i_clk,
   input  logic     i_rst_n,
   input  logic     i_push,
   input  payload_t i_data,
   input  logic     i_pop,
   output payload_t o_head,
   output logic     o_full,
   output logic     o_empty
);

   payload_t                     mem [DEPTH];   // circular storage.
   logic [$clog2(DEPTH)-1:0]     wr_ptr;
   logic [$clog2(DEPTH)-1:0]     rd_ptr;
   logic [$clog2(DEPTH+1)-1:0]   count;         // number of valid entries.
   logic                         do_push;
   logic                         do_pop;

   // a push into a full queue is taken only when the head leaves in the same cycle.
   assign do_push = i_push & (~o_full | i_pop);
   assign do_pop  = i_pop & ~o_empty;   // popping an empty queue does nothing.

   always_ff @(posedge i_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;   // wrap at the last slot.
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither leave the level unchanged.
         endcase
      end
   end

   // the head is shown without a register so the merge can decide in the same cycle.
   assign o_head  = mem[rd_ptr];
   assign o_full  = (count == DEPTH);
   assign o_empty = (count == 0);

endmodule

// ==== source/merge_pkg.sv ====
package merge_pkg;

   localparam int WORD_W    = 16;    // width of one stream word.
   localparam int IN_DEPTH  = 8;     // entries in each input queue.
   localparam int OUT_DEPTH = 8;     // entries in the output queue.

   // wishbone word addresses of the four host registers.
   localparam logic [1:0] ADDR_A    = 2'd0;   // stream A push.
   localparam logic [1:0] ADDR_B    = 2'd1;   // stream B push.
   localparam logic [1:0] ADDR_OUT  = 2'd2;   // merged word read and pop.
   localparam logic [1:0] ADDR_STAT = 2'd3;   // status with finished in bit 0.

   typedef logic [WORD_W-1:0] word_t;

   // one merged record as it sits in the output queue.
   typedef struct packed {
      logic  lane;   // flips after every terminator.
      word_t word;   // zero marks the end of a merged run.
   } merge_out_t;

   typedef enum logic [2:0] {
      NOMINAL  = 3'b000,
      TOGGLE   = 3'b001,
      DONE_A   = 3'b010,
      DONE_B   = 3'b011,
      FINISHED = 3'b100
   } merge_state_t;

   // head status of both input queues as seen by the control.
   typedef struct packed {
      logic a_zero;        // head of A is a terminator.
      logic b_zero;        // head of B is a terminator.
      logic a_empty;
      logic b_empty;
      logic a_last_zero;   // the last word popped from A was a terminator.
      logic b_last_zero;   // the last word popped from B was a terminator.
   } head_flags_t;

   // one cycle of work for the datapath.
   typedef struct packed {
      logic pop_a;
      logic pop_b;
      logic push;
      logic select_a;   // the pushed word is taken from the A head.
   } merge_cmd_t;

endpackage
